// File: src/doa_pkg.sv
package doa_pkg;

    // Sample fields
    typedef logic signed [15:0] coord_t;
    typedef logic        [15:0] mag_t;

    // Radians in signed 3.13 fixed point
    typedef logic signed [15:0] angle_t;

    localparam int SECTOR_COUNT  = 16;
    localparam int SECTOR_GROUPS = 4;                            // First stage of the max search
    localparam int GROUP_SIZE    = SECTOR_COUNT / SECTOR_GROUPS;

    typedef logic [$clog2(SECTOR_COUNT)-1:0] sector_t;

    // Frame size and the sum width that holds a full frame
    localparam int FRAME_SAMPLES = 16;
    localparam int SUM_W         = $bits(mag_t) + $clog2(FRAME_SAMPLES);
    localparam int COUNT_W       = $clog2(FRAME_SAMPLES) + 1;

    typedef logic [SUM_W-1:0]   sum_t;
    typedef logic [COUNT_W-1:0] count_t;

    // CORDIC datapath
    localparam int CORDIC_STAGES = 14;
    localparam int ANGLE_LATENCY = CORDIC_STAGES + 2;            // Pre-rotation and output register
    localparam int CORDIC_W      = $bits(coord_t) + 3;           // Headroom for negation and gain

    typedef logic signed [CORDIC_W-1:0] cordic_t;

    // atan(2^-i) scaled by 2^13
    localparam angle_t CORDIC_ATAN_TABLE [CORDIC_STAGES] = '{
        16'sd6434, 16'sd3798, 16'sd2007, 16'sd1019,
        16'sd511,  16'sd256,  16'sd128,  16'sd64,
        16'sd32,   16'sd16,   16'sd8,    16'sd4,
        16'sd2,    16'sd1
    };

    // Multiples of pi/8 from 0 up to pi
    localparam angle_t SECTOR_EDGES [9] = '{
        16'sh0000, // 0
        16'sh0c91, // pi/8
        16'sh1922, // pi/4
        16'sh25b3, // 3pi/8
        16'sh3244, // pi/2
        16'sh3ed5, // 5pi/8
        16'sh4b66, // 3pi/4
        16'sh57f7, // 7pi/8
        16'sh6488  // pi
    };

    localparam angle_t ANGLE_PI = SECTOR_EDGES[8];

endpackage

// File: src/angle_cordic.sv
`timescale 1ns/1ns

module angle_cordic
    import doa_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,

    input  logic   in_valid,
    input  coord_t in_x,
    input  coord_t in_y,
    input  mag_t   in_mag,

    output logic   out_valid,
    output angle_t out_angle,
    output mag_t   out_mag
);

    // Entry 0 is the pre-rotation register, entry i+1 the output of stage i
    cordic_t x_pipe [CORDIC_STAGES+1];
    cordic_t y_pipe [CORDIC_STAGES+1];
    angle_t  z_pipe [CORDIC_STAGES+1];

    // Side band follows the datapath at equal depth
    mag_t                     mag_pipe [ANGLE_LATENCY];
    logic [ANGLE_LATENCY-1:0] valid_pipe;

    cordic_t in_x_ext;
    cordic_t in_y_ext;

    assign in_x_ext = cordic_t'(in_x); // Sign extended
    assign in_y_ext = cordic_t'(in_y);

    // Left half-plane is turned by pi so the stages only see |angle| < pi/2
    always_ff @(posedge clk_in) begin
        if (in_x < 0) begin
            x_pipe[0] <= -in_x_ext;
            y_pipe[0] <= -in_y_ext;
            z_pipe[0] <= (in_y < 0) ? -ANGLE_PI : ANGLE_PI;
        end else begin
            x_pipe[0] <= in_x_ext;
            y_pipe[0] <= in_y_ext;
            z_pipe[0] <= '0;
        end
    end

    // Micro-rotations driving y toward zero
    for (genvar i = 0; i < CORDIC_STAGES; i++) begin : g_stage
        always_ff @(posedge clk_in) begin
            if (y_pipe[i] < 0) begin
                // Rotate counter-clockwise
                x_pipe[i+1] <= x_pipe[i] - (y_pipe[i] >>> i);
                y_pipe[i+1] <= y_pipe[i] + (x_pipe[i] >>> i);
                z_pipe[i+1] <= z_pipe[i] - CORDIC_ATAN_TABLE[i];
            end else begin
                x_pipe[i+1] <= x_pipe[i] + (y_pipe[i] >>> i);
                y_pipe[i+1] <= y_pipe[i] - (x_pipe[i] >>> i);
                z_pipe[i+1] <= z_pipe[i] + CORDIC_ATAN_TABLE[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        out_angle <= z_pipe[CORDIC_STAGES]; // Output register
    end

    // Magnitude rides along untouched
    always_ff @(posedge clk_in) begin
        mag_pipe[0] <= in_mag;
        for (int k = 1; k < ANGLE_LATENCY; k++) begin
            mag_pipe[k] <= mag_pipe[k-1];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[ANGLE_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[ANGLE_LATENCY-1];
    assign out_mag   = mag_pipe[ANGLE_LATENCY-1];

    // Valid tag must be clean once the pipe is flushed by reset
    assert property (@(posedge clk_in) disable iff (rst_in) !$isunknown(out_valid))
        else $error("CORDIC output valid is unknown");

endmodule

// File: src/sector_accumulator.sv
`timescale 1ns/1ns

module sector_accumulator
    import doa_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,

    input  logic   sample_valid,
    output logic   sample_ready,

    input  logic   angle_valid,
    input  angle_t angle,
    input  mag_t   angle_mag,

    output sum_t   sector_sums [SECTOR_COUNT],
    output logic   frame_full,
    input  logic   frame_release
);

    count_t  admit_count;   // Samples sent into the CORDIC this frame
    count_t  arrive_count;  // Angles returned this frame
    logic    admit;
    sector_t arrive_sector;

    // Upper half maps to 0..7, lower half to 8..15
    function automatic sector_t angle_to_sector(input angle_t a);
        sector_t sec;
        if (a >= 0) begin
            sec = sector_t'(0);
            for (int k = 1; k < 8; k++) begin
                if (a >= SECTOR_EDGES[k]) begin
                    sec = sector_t'(k); // pi and above stay in sector 7
                end
            end
        end else begin
            sec = sector_t'(8); // Below -7pi/8, including just under -pi
            for (int k = 1; k < 8; k++) begin
                if (a >= -SECTOR_EDGES[8-k]) begin
                    sec = sector_t'(8 + k);
                end
            end
        end
        return sec;
    endfunction

    assign sample_ready  = (admit_count != count_t'(FRAME_SAMPLES));
    assign admit         = sample_valid && sample_ready;
    assign arrive_sector = angle_to_sector(angle);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            admit_count  <= '0;
            arrive_count <= '0;
            frame_full   <= 1'b0;
        end else if (frame_release) begin
            // Consumer took the result so open a new frame
            admit_count  <= '0;
            arrive_count <= '0;
            frame_full   <= 1'b0;
        end else begin
            if (admit) begin
                admit_count <= admit_count + 1'b1;
            end
            if (angle_valid) begin
                arrive_count <= arrive_count + 1'b1;
            end
            frame_full <= (arrive_count == count_t'(FRAME_SAMPLES));
        end
    end

    // Running sums per sector
    always_ff @(posedge clk_in) begin
        if (rst_in || frame_release) begin
            for (int s = 0; s < SECTOR_COUNT; s++) begin
                sector_sums[s] <= '0;
            end
        end else if (angle_valid) begin
            sector_sums[arrive_sector] <= sector_sums[arrive_sector] + sum_t'(angle_mag);
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in)
        admit_count <= count_t'(FRAME_SAMPLES))
        else $error("More samples admitted than one frame holds");

    // Nothing leaves the CORDIC that was not admitted in this frame
    assert property (@(posedge clk_in) disable iff (rst_in)
        arrive_count <= admit_count)
        else $error("Angle arrivals ran ahead of admitted samples");

endmodule

// File: src/peak_sector_finder.sv
`timescale 1ns/1ns

module peak_sector_finder
    import doa_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_in,

    input  sum_t    sector_sums [SECTOR_COUNT],
    input  logic    frame_full,
    output logic    frame_release,

    output logic    peak_valid,
    output sector_t peak_sector,
    output sum_t    peak_sum,
    input  logic    peak_ready
);

    sum_t    cand_max [SECTOR_GROUPS];
    sector_t cand_idx [SECTOR_GROUPS];
    sum_t    grp_max  [SECTOR_GROUPS];   // Stage 1 registers
    sector_t grp_idx  [SECTOR_GROUPS];
    logic    grp_valid;
    sum_t    best_sum;
    sector_t best_idx;

    // Strict compare keeps the lower index on a tie
    always_comb begin
        for (int g = 0; g < SECTOR_GROUPS; g++) begin
            cand_max[g] = sector_sums[g*GROUP_SIZE];
            cand_idx[g] = sector_t'(g*GROUP_SIZE);
            for (int j = 1; j < GROUP_SIZE; j++) begin
                if (sector_sums[g*GROUP_SIZE + j] > cand_max[g]) begin
                    cand_max[g] = sector_sums[g*GROUP_SIZE + j];
                    cand_idx[g] = sector_t'(g*GROUP_SIZE + j);
                end
            end
        end
    end

    always_comb begin
        best_sum = grp_max[0];
        best_idx = grp_idx[0];
        for (int g = 1; g < SECTOR_GROUPS; g++) begin
            if (grp_max[g] > best_sum) begin
                best_sum = grp_max[g];
                best_idx = grp_idx[g];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        grp_max <= cand_max;
        grp_idx <= cand_idx;
        if (!peak_valid) begin // Hold while offered
            peak_sum    <= best_sum;
            peak_sector <= best_idx;
        end
    end

    assign frame_release = peak_valid && peak_ready;

    always_ff @(posedge clk_in) begin
        if (rst_in || frame_release) begin
            grp_valid  <= 1'b0;
            peak_valid <= 1'b0;
        end else begin
            grp_valid  <= frame_full;
            peak_valid <= grp_valid;
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in)
        peak_valid && !peak_ready |=> peak_valid && $stable(peak_sector) && $stable(peak_sum))
        else $error("Peak result changed while waiting for the consumer");

endmodule

// File: src/direction_finder_top.sv
`timescale 1ns/1ns

module direction_finder_top
    import doa_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_in,

    // Sample stream
    input  logic    sample_valid,
    input  coord_t  sample_x,
    input  coord_t  sample_y,
    input  mag_t    sample_mag,
    output logic    sample_ready,

    // Frame result
    output logic    peak_valid,
    output sector_t peak_sector,
    output sum_t    peak_sum,
    input  logic    peak_ready
);

    logic   sample_take;
    logic   angle_valid;
    angle_t angle;
    mag_t   angle_mag;
    sum_t   sector_sums [SECTOR_COUNT];
    logic   frame_full;
    logic   frame_release;

    // Only admitted samples enter the CORDIC
    assign sample_take = sample_valid && sample_ready;

    angle_cordic cordic_inst (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_valid  (sample_take),
        .in_x      (sample_x),
        .in_y      (sample_y),
        .in_mag    (sample_mag),
        .out_valid (angle_valid),
        .out_angle (angle),
        .out_mag   (angle_mag)
    );

    sector_accumulator accum_inst (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .sample_valid  (sample_valid),
        .sample_ready  (sample_ready),
        .angle_valid   (angle_valid),
        .angle         (angle),
        .angle_mag     (angle_mag),
        .sector_sums   (sector_sums),
        .frame_full    (frame_full),
        .frame_release (frame_release)
    );

    peak_sector_finder finder_inst (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .sector_sums   (sector_sums),
        .frame_full    (frame_full),
        .frame_release (frame_release),
        .peak_valid    (peak_valid),
        .peak_sector   (peak_sector),
        .peak_sum      (peak_sum),
        .peak_ready    (peak_ready)
    );

endmodule

// File: verification/direction_finder_tb.sv
`timescale 1ns/1ns

module direction_finder_tb
    import doa_pkg::*;
();

    localparam int SAMPLE_TIMEOUT = 200;   // Cycles
    localparam int PEAK_TIMEOUT   = 64;
    localparam int MAX_HOLD       = 30;

    logic    clk_in;
    logic    rst_in;
    logic    sample_valid;
    coord_t  sample_x;
    coord_t  sample_y;
    mag_t    sample_mag;
    logic    sample_ready;
    logic    peak_valid;
    sector_t peak_sector;
    sum_t    peak_sum;
    logic    peak_ready;

    integer  seed;
    sum_t    exp_sums [SECTOR_COUNT];   // Totals built from the sample lines
    int      frame_samples;
    int      frame_count;

    direction_finder_top UUT (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample_valid (sample_valid),
        .sample_x     (sample_x),
        .sample_y     (sample_y),
        .sample_mag   (sample_mag),
        .sample_ready (sample_ready),
        .peak_valid   (peak_valid),
        .peak_sector  (peak_sector),
        .peak_sum     (peak_sum),
        .peak_ready   (peak_ready)
    );

    always #20 clk_in = ~clk_in;

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_sector(input string name, input sector_t got, input sector_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_sum(input string name, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Largest total, lowest index wins a tie
    function automatic sector_t peak_of_sums();
        sector_t best;
        best = '0;
        for (int s = 1; s < SECTOR_COUNT; s++) begin
            if (exp_sums[sector_t'(s)] > exp_sums[best]) begin
                best = sector_t'(s);
            end
        end
        return best;
    endfunction

    // Called on a falling edge, returns on the falling edge after the handshake
    task automatic send_sample(input coord_t x, input coord_t y, input mag_t mag);
        int waited;
        waited       = 0;
        sample_valid = 1'b1;
        sample_x     = x;
        sample_y     = y;
        sample_mag   = mag;
        while (sample_ready !== 1'b1) begin
            @(negedge clk_in);
            waited++;
            if (waited > SAMPLE_TIMEOUT) begin
                stop_on_error("Timed out waiting for sample_ready to accept a sample");
            end
        end
        @(negedge clk_in); // Taken on the rising edge in between
        sample_valid = 1'b0;
    endtask

    task automatic wait_peak();
        int waited;
        waited = 0;
        while (peak_valid !== 1'b1) begin
            @(negedge clk_in);
            waited++;
            if (waited > PEAK_TIMEOUT) begin
                stop_on_error("Timed out waiting for peak_valid after a full frame");
            end
        end
    endtask

    // Back-pressure with refused strobes, then one accept
    task automatic hold_and_accept(input sector_t exp_sector, input sum_t exp_sum);
        int hold_cycles;
        hold_cycles = int'({$random(seed)} % (MAX_HOLD + 1));
        for (int i = 0; i < hold_cycles; i++) begin
            sample_valid = 1'b1;
            sample_x     = coord_t'($random(seed));
            sample_y     = coord_t'($random(seed));
            sample_mag   = mag_t'($random(seed));
            @(negedge clk_in);
            check_flag("peak_valid", peak_valid, 1'b1);
            check_sector("peak_sector", peak_sector, exp_sector);
            check_sum("peak_sum", peak_sum, exp_sum);
            check_flag("sample_ready", sample_ready, 1'b0);
        end
        sample_valid = 1'b0;
        peak_ready   = 1'b1;
        @(negedge clk_in);
        peak_ready = 1'b0;
        check_flag("peak_valid", peak_valid, 1'b0);   // Dropped by the accept
        check_flag("sample_ready", sample_ready, 1'b1);
    endtask

    initial begin
        int               fd;
        int               code;
        int               x_val;
        int               y_val;
        int               mag_val;
        int               sec_val;
        int               sum_val;
        logic [7:0]       tag;
        logic [8*128-1:0] line_buf;
        logic             reading;
        sector_t          file_sector;
        sector_t          own_sector;
        sum_t             file_sum;

        clk_in        = 1'b0;
        rst_in        = 1'b1;
        sample_valid  = 1'b0;
        sample_x      = '0;
        sample_y      = '0;
        sample_mag    = '0;
        peak_ready    = 1'b0;
        seed          = 28;
        exp_sums      = '{default: '0};
        frame_samples = 0;
        frame_count   = 0;

        repeat (10) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);
        check_flag("sample_ready", sample_ready, 1'b1);
        check_flag("peak_valid", peak_valid, 1'b0);

        fd = $fopen("verification/direction_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open verification/direction_patterns.txt");
        end

        reading = 1'b1;
        while (reading) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                reading = 1'b0;
            end else if (tag == "#") begin
                code = $fgets(line_buf, fd); // Skip the rest of a comment line
            end else if (tag == "S") begin
                code = $fscanf(fd, "%d %d %d %d", x_val, y_val, mag_val, sec_val);
                if (code != 4) begin
                    stop_on_error("Malformed sample line in the pattern file");
                end
                if (sec_val < 0 || sec_val >= SECTOR_COUNT) begin
                    stop_on_error("Sample line names a sector out of range");
                end
                if (frame_samples == FRAME_SAMPLES) begin
                    stop_on_error("Pattern file holds too many samples for one frame");
                end
                exp_sums[sector_t'(sec_val)] = exp_sums[sector_t'(sec_val)] + sum_t'(mag_val);
                frame_samples++;
                send_sample(coord_t'(x_val), coord_t'(y_val), mag_t'(mag_val));
            end else if (tag == "F") begin
                code = $fscanf(fd, "%d %d", sec_val, sum_val);
                if (code != 2) begin
                    stop_on_error("Malformed frame line in the pattern file");
                end
                if (frame_samples != FRAME_SAMPLES) begin
                    stop_on_error("Frame line does not follow a full frame of samples");
                end
                file_sector = sector_t'(sec_val);
                file_sum    = sum_t'(sum_val);
                own_sector  = peak_of_sums();
                if (own_sector != file_sector || exp_sums[own_sector] != file_sum) begin
                    stop_on_error("Frame line disagrees with the totals of its sample lines");
                end

                // Frame is closed once the last sample went in
                check_flag("sample_ready", sample_ready, 1'b0);
                wait_peak();
                check_sector("peak_sector", peak_sector, file_sector);
                check_sum("peak_sum", peak_sum, file_sum);
                hold_and_accept(file_sector, file_sum);

                exp_sums      = '{default: '0};
                frame_samples = 0;
                frame_count++;
            end else begin
                stop_on_error("Unknown line type in the pattern file");
            end
        end
        $fclose(fd);

        if (frame_count == 0) begin
            stop_on_error("Pattern file held no complete frame");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: verification/direction_patterns.txt
# S x y magnitude expected_sector, all decimal
# F expected_peak_sector expected_peak_sum
# Frame 1, sector 2 dominant in the upper half-plane
S 5556 8315 3000 2
S 9808 1951 1200 0
S 2778 4158 2500 2
S -5556 8315 900 5
S 5556 8315 4000 2
S -9808 1951 1500 7
S 8315 5556 2200 1
S 11112 16630 3100 2
S 1951 9808 800 3
S -5556 -8315 1700 10
S 5556 8315 2800 2
S -8315 5556 1000 6
S -1951 9808 600 4
S 5556 8315 3600 2
S 5556 -8315 500 13
S 8315 5556 1400 1
F 2 19000
# Frame 2, sector 11 dominant in the lower half-plane, sums above 16 bits
S -1951 -9808 60000 11
S -9808 -1951 12000 8
S -1951 -9808 55000 11
S 9808 -1951 20000 15
S -8315 -5556 9000 9
S -3902 -19616 61000 11
S 8315 -5556 30000 14
S 1951 -9808 15000 12
S -1951 -9808 58000 11
S 5556 8315 40000 2
S -5556 -8315 7000 10
S -1951 -9808 62000 11
S 5556 -8315 25000 13
S 8315 -5556 33000 14
S 9808 1951 1000 0
S -9808 -1951 18000 8
F 11 296000
# Frame 3, sectors 5 and 13 tie, lower index expected
S -5556 8315 5000 5
S 5556 -8315 4000 13
S 1951 9808 2000 3
S 5556 -8315 3000 13
S -5556 8315 2500 5
S -8315 -5556 1000 9
S 5556 -8315 2500 13
S -5556 8315 3000 5
S 9808 1951 700 0
S 2778 -4158 2000 13
S 8315 -5556 1200 14
S -5556 8315 1000 5
S -8315 5556 900 6
S 8315 5556 3300 1
S 1951 -9808 2600 12
S -9808 1951 400 7
F 5 11500

// File: list.f
src/doa_pkg.sv
src/angle_cordic.sv
src/sector_accumulator.sv
src/peak_sector_finder.sv
src/direction_finder_top.sv
verification/direction_finder_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the direction finder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ns \
    --top-module direction_finder_tb \
    -Mdir obj_dir \
    -f list.f

# A failing run stops with a nonzero status, so keep the output for the search
sim_out=$(./obj_dir/Vdirection_finder_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
else
    exit 1
fi
